/* hw/core_shell_pkg.sv */
// Core shell package
// Register file geometry and the register-side types shared by the
// core shell and the register file
package core_shell_pkg;

  // Register file geometry
  parameter int unsigned RF_ADDR_W = 5;
  parameter int unsigned RF_DATA_W = 32;

  // Register index and register word
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [RF_DATA_W-1:0] rf_data_t;

  // One register write per cycle
  typedef struct packed {
    logic     we;
    rf_addr_t addr;
    rf_data_t data;
  } rf_wr_t;

endpackage

/* hw/icache_mem_pkg.sv */
// Instruction cache memory package
// Cache RAM geometry, payload and request types, scramble key types
// and the data scramble mask
package icache_mem_pkg;

  // Cache geometry
  parameter int unsigned IC_NUM_WAYS   = 2;
  parameter int unsigned IC_NUM_LINES  = 64;
  parameter int unsigned IC_INDEX_W    = $clog2(IC_NUM_LINES);
  parameter int unsigned IC_TAG_W      = 21;
  parameter int unsigned IC_LINE_BEATS = 2;
  parameter int unsigned IC_BEAT_W     = 32;

  // Scramble key material
  parameter int unsigned SCR_KEY_W   = 128;
  parameter int unsigned SCR_NONCE_W = 64;

  typedef logic [IC_INDEX_W-1:0]  ic_index_t;
  typedef logic [SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [SCR_NONCE_W-1:0] scr_nonce_t;

  typedef struct packed {
    logic                valid;
    logic [IC_TAG_W-1:0] tag;
  } ic_tag_t;

  // Beat 1 in the upper half
  typedef logic [IC_LINE_BEATS-1:0][IC_BEAT_W-1:0] ic_line_t;

  typedef struct packed {
    logic [IC_NUM_WAYS-1:0] req;
    logic                   write;
    ic_index_t              index;
    ic_tag_t                wdata;
  } ic_tag_req_t;

  typedef struct packed {
    logic [IC_NUM_WAYS-1:0] req;
    logic                   write;
    ic_index_t              index;
    ic_line_t               wdata;
  } ic_data_req_t;

  // Key XOR doubled nonce, line index folded into the low bits
  function automatic scr_key_t scramble_mask(input scr_key_t   key,
                                             input scr_nonce_t nonce,
                                             input ic_index_t  index);
    scr_key_t mask;
    mask = key ^ {nonce, nonce};
    mask[IC_INDEX_W-1:0] = mask[IC_INDEX_W-1:0] ^ index;
    return mask;
  endfunction

endpackage

/* hw/sleep_ctrl.sv */
// Sleep control
// Registers the core busy flag, merges it with the wake sources and
// gates the core clock through a latch-based clock gate
`timescale 1ns/1ps

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic debug_req_i,
  input  logic irq_nm_i,

  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic clock_en_latched;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake sources act in the same cycle, busy one cycle later
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////

  // Transparent while the clock is low
  always_latch begin
    if (!clk_i) begin
      clock_en_latched = clock_en;
    end
  end

  assign clk_gated_o = clk_i & clock_en_latched;

endmodule

/* hw/reg_file_ff.sv */
// Flip-flop register file
// Two combinational read ports and one write port, x0 hard-wired to
// zero, optionally cut down to 16 registers for RV32E
`timescale 1ns/1ps

module reg_file_ff #(
  parameter bit RV32E = 1'b0
) (
  // Gated core clock
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  core_shell_pkg::rf_wr_t   rf_wr_i,

  input  core_shell_pkg::rf_addr_t raddr_a_i,
  input  core_shell_pkg::rf_addr_t raddr_b_i,
  output core_shell_pkg::rf_data_t rdata_a_o,
  output core_shell_pkg::rf_data_t rdata_b_o
);

  localparam int unsigned NumRegs = RV32E ? 16 : 32;
  localparam int unsigned NumAddr = 2 ** core_shell_pkg::RF_ADDR_W;

  logic [NumRegs-1:1]       we_dec;
  core_shell_pkg::rf_data_t rf_q    [1:NumRegs-1];
  core_shell_pkg::rf_data_t rf_view [NumAddr];

  always_comb begin : write_decode
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = rf_wr_i.we && (rf_wr_i.addr == core_shell_pkg::rf_addr_t'(i));
    end
  end

  // x0 is not stored
  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= rf_wr_i.data;
      end
    end
  end

  // Unused entries of the full index space read as zero
  always_comb begin : read_view
    rf_view = '{default: '0};
    for (int unsigned i = 1; i < NumRegs; i++) begin
      rf_view[i] = rf_q[i];
    end
  end

  assign rdata_a_o = rf_view[raddr_a_i];
  assign rdata_b_o = rf_view[raddr_b_i];

endmodule

/* hw/scramble_key_mgr.sv */
// Scramble key manager
// Holds the cache scramble key and nonce and renews them through a
// request/valid handshake started by a cache invalidate
`timescale 1ns/1ps

module scramble_key_mgr #(
  parameter icache_mem_pkg::scr_key_t   RndCnstKey   = '0,
  parameter icache_mem_pkg::scr_nonce_t RndCnstNonce = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       icache_inval_i,

  // Key source handshake
  input  logic                       scramble_key_valid_i,
  input  icache_mem_pkg::scr_key_t   scramble_key_i,
  input  icache_mem_pkg::scr_nonce_t scramble_nonce_i,
  output logic                       scramble_req_o,

  // Current key towards the RAMs
  output logic                       key_valid_o,
  output icache_mem_pkg::scr_key_t   key_o,
  output icache_mem_pkg::scr_nonce_t nonce_o
);

  logic req_d, req_q;
  logic key_valid_d, key_valid_q;

  icache_mem_pkg::scr_key_t   key_q;
  icache_mem_pkg::scr_nonce_t nonce_q;

  // Request raised by invalidate, held until the key arrives
  assign req_d = req_q ? ~scramble_key_valid_i : icache_inval_i;

  // Key stays invalid for the whole request
  assign key_valid_d = req_q          ? scramble_key_valid_i :
                       icache_inval_i ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= RndCnstKey;
      nonce_q <= RndCnstNonce;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

endmodule

/* hw/icache_ram_bank.sv */
// Scrambled cache RAM bank
// Single-port storage for one tag or line bank, data XORed with a mask
// from the current key, nonce and line index on write and on read
`timescale 1ns/1ps

module icache_ram_bank #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       req_i,
  input  logic                       write_i,
  input  icache_mem_pkg::ic_index_t  addr_i,
  input  payload_t                   wdata_i,

  input  logic                       key_valid_i,
  input  icache_mem_pkg::scr_key_t   key_i,
  input  icache_mem_pkg::scr_nonce_t nonce_i,

  output payload_t                   rdata_o
);

  localparam int unsigned Width = $bits(payload_t);

  icache_mem_pkg::scr_key_t mask_full;
  logic [Width-1:0]         mask;
  logic [Width-1:0]         mem_q [icache_mem_pkg::IC_NUM_LINES];
  payload_t                 rdata_q;

  assign mask_full = icache_mem_pkg::scramble_mask(key_i, nonce_i, addr_i);
  assign mask      = mask_full[Width-1:0];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && write_i && key_valid_i) begin
      mem_q[addr_i] <= wdata_i ^ mask;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (!key_valid_i) begin
      rdata_q <= '0;
    end else if (req_i && !write_i) begin
      rdata_q <= payload_t'(mem_q[addr_i] ^ mask);
    end
  end

  // Nothing leaks out while the key is being renewed
  assign rdata_o = key_valid_i ? rdata_q : payload_t'('0);

endmodule

/* hw/core_shell_top.sv */
// Core shell top level
// Clock gating, register file, scramble key handling and the scrambled
// instruction cache RAMs that surround the core
`timescale 1ns/1ps

module core_shell_top #(
  parameter bit                         RV32E        = 1'b0,
  parameter icache_mem_pkg::scr_key_t   RndCnstKey   =
      128'h3c9a_51e7_0d84_f26b_a5c1_7e39_b40f_d286,
  parameter icache_mem_pkg::scr_nonce_t RndCnstNonce = 64'h9e17_c2a4_58f0_3bd6
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Sleep and wake
  input  logic                         core_busy_i,
  input  logic                         irq_pending_i,
  input  logic                         debug_req_i,
  input  logic                         irq_nm_i,
  output logic                         core_sleep_o,

  // Register file
  input  core_shell_pkg::rf_wr_t       rf_wr_i,
  input  core_shell_pkg::rf_addr_t     rf_raddr_a_i,
  input  core_shell_pkg::rf_addr_t     rf_raddr_b_i,
  output core_shell_pkg::rf_data_t     rf_rdata_a_o,
  output core_shell_pkg::rf_data_t     rf_rdata_b_o,

  // Instruction cache RAMs
  input  icache_mem_pkg::ic_tag_req_t  ic_tag_req_i,
  input  icache_mem_pkg::ic_data_req_t ic_data_req_i,
  output icache_mem_pkg::ic_tag_t      ic_tag_rdata_o  [icache_mem_pkg::IC_NUM_WAYS],
  output icache_mem_pkg::ic_line_t     ic_data_rdata_o [icache_mem_pkg::IC_NUM_WAYS],

  // Scramble key interface
  input  logic                         icache_inval_i,
  input  logic                         scramble_key_valid_i,
  input  icache_mem_pkg::scr_key_t     scramble_key_i,
  input  icache_mem_pkg::scr_nonce_t   scramble_nonce_i,
  output logic                         scramble_req_o
);

  logic                       clk_gated;
  logic                       key_valid;
  icache_mem_pkg::scr_key_t   scr_key;
  icache_mem_pkg::scr_nonce_t scr_nonce;

  //////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_busy_i   (core_busy_i),
    .irq_pending_i (irq_pending_i),
    .debug_req_i   (debug_req_i),
    .irq_nm_i      (irq_nm_i),
    .clk_gated_o   (clk_gated),
    .core_sleep_o  (core_sleep_o)
  );

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  // Writes only land while the core clock runs
  reg_file_ff #(
    .RV32E (RV32E)
  ) u_reg_file (
    .clk_i     (clk_gated),
    .rst_ni    (rst_ni),
    .rf_wr_i   (rf_wr_i),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o)
  );

  //////////////////////////////////////////////////
  // Scramble key
  //////////////////////////////////////////////////

  scramble_key_mgr #(
    .RndCnstKey   (RndCnstKey),
    .RndCnstNonce (RndCnstNonce)
  ) u_scramble_key_mgr (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .icache_inval_i       (icache_inval_i),
    .scramble_key_valid_i (scramble_key_valid_i),
    .scramble_key_i       (scramble_key_i),
    .scramble_nonce_i     (scramble_nonce_i),
    .scramble_req_o       (scramble_req_o),
    .key_valid_o          (key_valid),
    .key_o                (scr_key),
    .nonce_o              (scr_nonce)
  );

  //////////////////////////////////////////////////
  // Cache RAMs
  //////////////////////////////////////////////////

  for (genvar way = 0; way < icache_mem_pkg::IC_NUM_WAYS; way++) begin : gen_ways

    icache_ram_bank #(
      .payload_t (icache_mem_pkg::ic_tag_t)
    ) u_tag_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (ic_tag_req_i.req[way]),
      .write_i     (ic_tag_req_i.write),
      .addr_i      (ic_tag_req_i.index),
      .wdata_i     (ic_tag_req_i.wdata),
      .key_valid_i (key_valid),
      .key_i       (scr_key),
      .nonce_i     (scr_nonce),
      .rdata_o     (ic_tag_rdata_o[way])
    );

    icache_ram_bank #(
      .payload_t (icache_mem_pkg::ic_line_t)
    ) u_data_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (ic_data_req_i.req[way]),
      .write_i     (ic_data_req_i.write),
      .addr_i      (ic_data_req_i.index),
      .wdata_i     (ic_data_req_i.wdata),
      .key_valid_i (key_valid),
      .key_i       (scr_key),
      .nonce_i     (scr_nonce),
      .rdata_o     (ic_data_rdata_o[way])
    );

  end

endmodule

/* tests/tb_core_shell.sv */
// Core shell testbench
// Plays the core side and checks sleep gating, the register file, the
// scrambled cache RAMs and key renewal against reference models
`timescale 1ns/1ps

module tb_core_shell;

  localparam bit           RV32E       = 1'b1;
  localparam logic [127:0] RESET_KEY   = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
  localparam logic [63:0]  RESET_NONCE = 64'h5a5a_c3c3_1234_fedc;
  localparam int NUM_WAYS = icache_mem_pkg::IC_NUM_WAYS;
  localparam int TAG_W    = $bits(icache_mem_pkg::ic_tag_t);
  localparam int LINE_W   = $bits(icache_mem_pkg::ic_line_t);
  localparam int ENTRIES  = 8;
  // Whole run takes under 200 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk_i;
  logic rst_ni;
  logic core_busy_i;
  logic irq_pending_i;
  logic debug_req_i;
  logic irq_nm_i;
  logic core_sleep_o;
  core_shell_pkg::rf_wr_t       rf_wr_i;
  core_shell_pkg::rf_addr_t     rf_raddr_a_i;
  core_shell_pkg::rf_addr_t     rf_raddr_b_i;
  core_shell_pkg::rf_data_t     rf_rdata_a_o;
  core_shell_pkg::rf_data_t     rf_rdata_b_o;
  icache_mem_pkg::ic_tag_req_t  ic_tag_req_i;
  icache_mem_pkg::ic_data_req_t ic_data_req_i;
  icache_mem_pkg::ic_tag_t      ic_tag_rdata_o  [NUM_WAYS];
  icache_mem_pkg::ic_line_t     ic_data_rdata_o [NUM_WAYS];
  logic                         icache_inval_i;
  logic                         scramble_key_valid_i;
  icache_mem_pkg::scr_key_t     scramble_key_i;
  icache_mem_pkg::scr_nonce_t   scramble_nonce_i;
  logic                         scramble_req_o;

  // RAM shadows hold the scrambled words
  logic [31:0]       rf_model [32];
  logic [TAG_W-1:0]  tag_raw  [NUM_WAYS][64];
  logic [LINE_W-1:0] line_raw [NUM_WAYS][64];
  int                wr_idx   [NUM_WAYS][ENTRIES];
  logic [127:0]      cur_key;
  logic [63:0]       cur_nonce;

  // Expected values armed on the falling edge
  logic              chk_sleep;
  logic              exp_sleep;
  logic              chk_req;
  logic              exp_req;
  logic              chk_rf;
  logic [31:0]       exp_rdata_a;
  logic [31:0]       exp_rdata_b;
  logic              chk_tag  [NUM_WAYS];
  logic [TAG_W-1:0]  exp_tag  [NUM_WAYS];
  logic              chk_line [NUM_WAYS];
  logic [LINE_W-1:0] exp_line [NUM_WAYS];

  int errors;
  int checks;
  int tests_done;
  int test_err_start;
  int cycle_cnt;

  core_shell_top #(
    .RV32E        (RV32E),
    .RndCnstKey   (RESET_KEY),
    .RndCnstNonce (RESET_NONCE)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [127:0] ref_mask(input logic [127:0] key,
                                            input logic [63:0] nonce, input int idx);
    logic [127:0] m;
    m = key ^ {nonce, nonce};
    m[5:0] = m[5:0] ^ idx[5:0];
    return m;
  endfunction

  function automatic logic [31:0] rf_expect(input int addr);
    if (addr == 0 || (RV32E && addr >= 16)) begin
      return '0;
    end
    return rf_model[addr];
  endfunction

  // Mask is its own inverse, so this both scrambles and unscrambles
  function automatic logic [LINE_W-1:0] ram_expect(input logic [LINE_W-1:0] word, input int idx);
    logic [127:0] m;
    m = ref_mask(cur_key, cur_nonce, idx);
    return word ^ m[LINE_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_i) begin
    if (chk_sleep) compare("core_sleep_o", 64'(core_sleep_o), 64'(exp_sleep));
    if (chk_req) compare("scramble_req_o", 64'(scramble_req_o), 64'(exp_req));
    if (chk_rf) begin
      compare("rf_rdata_a_o", 64'(rf_rdata_a_o), 64'(exp_rdata_a));
      compare("rf_rdata_b_o", 64'(rf_rdata_b_o), 64'(exp_rdata_b));
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (chk_tag[w]) begin
        compare($sformatf("ic_tag_rdata_o[%0d]", w), 64'(ic_tag_rdata_o[w]), 64'(exp_tag[w]));
      end
      if (chk_line[w]) begin
        compare($sformatf("ic_data_rdata_o[%0d]", w), ic_data_rdata_o[w], exp_line[w]);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Pulses and checks back to idle
  task automatic go_idle();
    chk_sleep = 1'b0;
    chk_req = 1'b0;
    chk_rf = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      chk_tag[w] = 1'b0;
      chk_line[w] = 1'b0;
    end
    rf_wr_i = '0;
    ic_tag_req_i = '0;
    ic_data_req_i = '0;
    icache_inval_i = 1'b0;
    scramble_key_valid_i = 1'b0;
  endtask

  task automatic step();
    @(negedge clk_i);
    go_idle();
  endtask

  task automatic expect_regs(input int a, input int b);
    rf_raddr_a_i = core_shell_pkg::rf_addr_t'(a);
    rf_raddr_b_i = core_shell_pkg::rf_addr_t'(b);
    exp_rdata_a = rf_expect(a);
    exp_rdata_b = rf_expect(b);
    chk_rf = 1'b1;
  endtask

  task automatic expect_sleep(input logic value);
    chk_sleep = 1'b1;
    exp_sleep = value;
  endtask

  task automatic expect_ram_zero();
    for (int w = 0; w < NUM_WAYS; w++) begin
      chk_tag[w] = 1'b1;
      exp_tag[w] = '0;
      chk_line[w] = 1'b1;
      exp_line[w] = '0;
    end
  endtask

  task automatic write_rf(input int addr, input logic [31:0] data);
    rf_wr_i.we = 1'b1;
    rf_wr_i.addr = core_shell_pkg::rf_addr_t'(addr);
    rf_wr_i.data = data;
  endtask

  task automatic read_entry(input int w, input int idx);
    step();
    ic_tag_req_i.req[w] = 1'b1;
    ic_tag_req_i.index = icache_mem_pkg::ic_index_t'(idx);
    ic_data_req_i.req[w] = 1'b1;
    ic_data_req_i.index = icache_mem_pkg::ic_index_t'(idx);
    step();
    chk_tag[w] = 1'b1;
    exp_tag[w] = TAG_W'(ram_expect(LINE_W'(tag_raw[w][idx]), idx));
    chk_line[w] = 1'b1;
    exp_line[w] = ram_expect(line_raw[w][idx], idx);
  endtask

  task automatic end_test(input string name);
    step();
    tests_done++;
    $display("Test %0d %s: %0d errors", tests_done, name, errors - test_err_start);
    test_err_start = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int a;
    int r;
    int idx;
    int delay;
    logic [31:0] d;
    logic [TAG_W-1:0] t;
    logic [LINE_W-1:0] ln;
    void'($urandom(32'h4152fc67));
    {errors, checks, tests_done, test_err_start} = '0;
    rst_ni = 1'b0;
    {core_busy_i, irq_pending_i, debug_req_i, irq_nm_i} = '0;
    {rf_raddr_a_i, rf_raddr_b_i} = '0;
    scramble_key_i = '0;
    scramble_nonce_i = '0;
    go_idle();
    cur_key = RESET_KEY;
    cur_nonce = RESET_NONCE;
    for (int i = 0; i < 32; i++) rf_model[i] = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    step();
    expect_regs(1 + $urandom % 31, $urandom % 32);
    expect_sleep(1'b1);
    chk_req = 1'b1;
    exp_req = 1'b0;
    end_test("reset state");

    // Busy takes a cycle to register, another to open the gate
    core_busy_i = 1'b1;
    step();
    step();
    for (int i = 0; i < 40; i++) begin
      step();
      a = (i % 8 == 0) ? 0 : $urandom % 32;
      d = $urandom;
      write_rf(a, d);
      expect_regs($urandom % 32, (i % 4 == 0) ? 0 : $urandom % 32);
      expect_sleep(1'b0);
      if (a != 0 && !(RV32E && a >= 16)) rf_model[a] = d;
    end
    end_test("register file");

    r = 1 + $urandom % 15;
    core_busy_i = 1'b0;
    expect_sleep(1'b0);
    step();
    expect_sleep(1'b1);
    write_rf(r, $urandom);
    expect_regs(r, 0);
    step();
    expect_sleep(1'b1);
    expect_regs(r, 0);
    step();
    irq_nm_i = 1'b1;
    expect_sleep(1'b0);
    d = $urandom;
    write_rf(r, d);
    expect_regs(r, 0);
    rf_model[r] = d;
    step();
    expect_sleep(1'b0);
    expect_regs(r, 0);
    step();
    irq_nm_i = 1'b0;
    irq_pending_i = 1'b1;
    expect_sleep(1'b0);
    step();
    irq_pending_i = 1'b0;
    debug_req_i = 1'b1;
    expect_sleep(1'b0);
    step();
    debug_req_i = 1'b0;
    expect_sleep(1'b1);
    step();
    core_busy_i = 1'b1;
    end_test("sleep and wake");

    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int k = 0; k < ENTRIES; k++) begin
        step();
        idx = 8 * k + $urandom % 8;
        wr_idx[w][k] = idx;
        t = TAG_W'($urandom);
        ln = {$urandom, $urandom};
        ic_tag_req_i = '{req: 2'(1 << w), write: 1'b1,
                         index: icache_mem_pkg::ic_index_t'(idx), wdata: t};
        ic_data_req_i = '{req: 2'(1 << w), write: 1'b1,
                          index: icache_mem_pkg::ic_index_t'(idx), wdata: ln};
        tag_raw[w][idx] = TAG_W'(ram_expect(LINE_W'(t), idx));
        line_raw[w][idx] = ram_expect(ln, idx);
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int k = 0; k < ENTRIES; k++) read_entry(w, wr_idx[w][k]);
    end
    end_test("RAM round trip");

    icache_inval_i = 1'b1;
    chk_req = 1'b1;
    exp_req = 1'b0;
    delay = 2 + $urandom % 6;
    repeat (delay) begin
      step();
      chk_req = 1'b1;
      exp_req = 1'b1;
      ic_tag_req_i.req = '1;
      ic_tag_req_i.index = icache_mem_pkg::ic_index_t'(wr_idx[0][0]);
      ic_data_req_i.req = '1;
      ic_data_req_i.index = icache_mem_pkg::ic_index_t'(wr_idx[0][0]);
      expect_ram_zero();
    end
    step();
    scramble_key_valid_i = 1'b1;
    scramble_key_i = {$urandom, $urandom, $urandom, $urandom};
    scramble_nonce_i = {$urandom, $urandom};
    chk_req = 1'b1;
    exp_req = 1'b1;
    expect_ram_zero();
    cur_key = scramble_key_i;
    cur_nonce = scramble_nonce_i;
    step();
    chk_req = 1'b1;
    exp_req = 1'b0;
    expect_ram_zero();
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int k = 0; k < ENTRIES; k++) read_entry(w, wr_idx[w][k]);
    end
    end_test("key renewal");

    $display("Tests: %0d  checks: %0d  errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* files.f */
hw/core_shell_pkg.sv
hw/icache_mem_pkg.sv
hw/sleep_ctrl.sv
hw/reg_file_ff.sv
hw/scramble_key_mgr.sv
hw/icache_ram_bank.sv
hw/core_shell_top.sv
tests/tb_core_shell.sv
